// ==== mem_channel_top.f ====
+incdir+include
logic/mem_link_pkg.sv
logic/mem_channel_if.sv
logic/mem_cmd_arbiter.sv
logic/mem_model.sv
logic/mem_resp_router.sv
logic/mem_channel_top.sv
verification/mem_channel_properties.sv
verification/mem_channel_tb.sv

// ==== verification/mem_channel_tb.sv ====
//********************
// Memory channel testbench
// Random traffic on all ports, checked against a reference memory
//********************

`timescale 1ns/100ps

`include "mem_link_consts.svh"

module mem_channel_tb
  import mem_link_pkg::*;
  ();

  localparam int N         = `MEM_NUM_PORTS;
  localparam int NUM_CMDS  = 400;
  // Commands after this one keep every port valid and ready
  localparam int RAND_CMDS = 300;
  localparam int TIMEOUT   = NUM_CMDS * (`MEM_LATENCY + 8) + 200;
  localparam logic [31:0] TAPS = 32'h8020_0003;

  logic         clk_i = 1'b0;
  logic         rst_i;
  logic [N-1:0] cmd_v_i;
  mem_cmd_s     cmd_i [N];
  logic [N-1:0] cmd_yumi_o;
  logic [N-1:0] resp_v_o;
  mem_resp_s    resp_o [N];
  logic [N-1:0] resp_ready_i;

  logic [31:0]            lfsr = 32'h5967;
  logic [`MEM_DATA_W-1:0] ref_mem [2**`MEM_ADDR_W];
  bit                     written [2**`MEM_ADDR_W];
  mem_resp_s              exp_q [N][$];
  int                     issued = 0;
  int                     resp_count = 0;
  int                     data_errors = 0;

  mem_channel_top mem_channel_top_inst
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .cmd_v_i(cmd_v_i)
     , .cmd_i(cmd_i)
     , .cmd_yumi_o(cmd_yumi_o)
     , .resp_v_o(resp_v_o)
     , .resp_o(resp_o)
     , .resp_ready_i(resp_ready_i)
     );

  always #2 clk_i = ~clk_i;

  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic bit drained();
    bit empty;
    empty = (issued == NUM_CMDS) && (cmd_v_i == '0);
    for (int p = 0; p < N; p++)
      empty &= (exp_q[p].size() == 0);
    return empty;
  endfunction

  always @(posedge clk_i)
  begin : bench
    mem_cmd_s    nxt;
    mem_resp_s   want;
    logic [31:0] r;
    if (!rst_i)
    begin
      for (int p = 0; p < N; p++)
      begin
        if (resp_v_o[p] && resp_ready_i[p])
        begin
          resp_count++;
          assert (exp_q[p].size() > 0)
          else
          begin
            $display("Unexpected response on port %0d at %0t with nothing outstanding",
                     p, $time);
            data_errors++;
          end
          if (exp_q[p].size() > 0)
          begin
            want = exp_q[p].pop_front();
            assert (resp_o[p] === want)
            else
            begin
              $display("ERROR %0t resp_o[%0d] expected %h actual %h",
                       $time, p, want, resp_o[p]);
              data_errors++;
            end
          end
        end
      end
      // Reference memory follows acceptance order
      for (int p = 0; p < N; p++)
      begin
        if (cmd_v_i[p] && cmd_yumi_o[p])
        begin
          want.op   = cmd_i[p].op;
          want.addr = cmd_i[p].addr;
          want.data = (cmd_i[p].op == MEM_WR) ? cmd_i[p].data : ref_mem[cmd_i[p].addr];
          if (cmd_i[p].op == MEM_WR)
          begin
            ref_mem[cmd_i[p].addr] = cmd_i[p].data;
            written[cmd_i[p].addr] = 1'b1;
          end
          exp_q[p].push_back(want);
        end
      end
      for (int p = 0; p < N; p++)
      begin
        if (!cmd_v_i[p] || cmd_yumi_o[p])
        begin
          if ((issued < NUM_CMDS) && ((issued >= RAND_CMDS) || take_bits(1)))
          begin
            // Small address window plus the top bit, so reads hit earlier writes
            r                       = take_bits(6);
            nxt.addr                = '0;
            nxt.addr[4:0]           = r[4:0];
            nxt.addr[`MEM_ADDR_W-1] = r[5];
            nxt.op   = (written[nxt.addr] && take_bits(1)) ? MEM_RD : MEM_WR;
            nxt.data = take_bits(`MEM_DATA_W);
            cmd_i[p]   <= nxt;
            cmd_v_i[p] <= 1'b1;
            issued++;
          end
          else
            cmd_v_i[p] <= 1'b0;
        end
        resp_ready_i[p] <= (issued >= RAND_CMDS) || (take_bits(2) != 0);
      end
    end
  end

  initial
  begin : main
    int proto_errors;
    rst_i        = 1'b1;
    cmd_v_i      = '0;
    resp_ready_i = '0;
    for (int p = 0; p < N; p++)
      cmd_i[p] = '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    do
      @(negedge clk_i);
    while (!drained());
    assert (resp_count == NUM_CMDS)
    else
    begin
      $display("Only %0d of %0d responses came back", resp_count, NUM_CMDS);
      data_errors++;
    end
    proto_errors = mem_channel_top_inst.mem_channel_properties_inst.fail_count;
    $display("Data errors: %0d, protocol errors: %0d", data_errors, proto_errors);
    if ((data_errors == 0) && (proto_errors == 0))
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin : watchdog
    repeat (TIMEOUT) @(posedge clk_i);
    $display("Run timed out after %0d cycles with commands or responses outstanding",
             TIMEOUT);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== verification/mem_channel_properties.sv ====
//********************
// Memory channel protocol checks
// Concurrent assertions bound to the top level
//********************

`timescale 1ns/100ps

`include "mem_link_consts.svh"

module mem_channel_properties
  import mem_link_pkg::*;
  (input  logic                      clk_i
   , input  logic                      rst_i
   , input  logic [`MEM_NUM_PORTS-1:0] cmd_v_i
   , input  logic [`MEM_NUM_PORTS-1:0] cmd_yumi_o
   , input  logic [`MEM_NUM_PORTS-1:0] resp_v_o
   , input  mem_resp_s                 resp_o [`MEM_NUM_PORTS]
   , input  logic [`MEM_NUM_PORTS-1:0] resp_ready_i
   );

  localparam int N = `MEM_NUM_PORTS;

  int fail_count = 0;

  task automatic record_failure(input string what);
    $error("%s", what);
    fail_count++;
  endtask

  // Nothing comes out of a freshly reset channel
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> ((cmd_yumi_o == '0) && (resp_v_o == '0)))
    else record_failure("cmd_yumi_o or resp_v_o high right after reset");

  a_yumi_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_yumi_o & ~cmd_v_i) == '0)
    else record_failure("cmd_yumi_o high on a port without cmd_v_i");

  a_resp_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(resp_v_o))
    else record_failure("resp_v_o high on more than one port");

  for (genvar p = 0; p < N; p++)
  begin : g_port
    // All ports ready, so no stall between acceptance and response
    a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      cmd_yumi_o[p] ##1 (&resp_ready_i)[*(`MEM_LATENCY-1)] |=> resp_v_o[p])
      else record_failure("response missed the fixed latency");

    // Next grant goes elsewhere while another port waits
    a_round_robin: assert property (@(posedge clk_i) disable iff (rst_i)
      (cmd_yumi_o[p] && ((cmd_v_i & ~cmd_yumi_o) != '0))
        |=> (!cmd_yumi_o[p] until_with (cmd_yumi_o != '0)))
      else record_failure("port granted again ahead of a waiting port");

    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (resp_v_o[p] && !resp_ready_i[p]) |=> (resp_v_o[p] && $stable(resp_o[p])))
      else record_failure("response dropped or changed under back-pressure");
  end

endmodule

bind mem_channel_top mem_channel_properties mem_channel_properties_inst (.*);

// ==== logic/mem_channel_top.sv ====
//********************
// Shared memory channel
// Arbiter, fixed-latency model and response router
//********************

`timescale 1ns/100ps

`include "mem_link_consts.svh"

module mem_channel_top
  import mem_link_pkg::*;
  (input  logic                      clk_i
   , input  logic                      rst_i
   , input  logic [`MEM_NUM_PORTS-1:0] cmd_v_i
   , input  mem_cmd_s                  cmd_i [`MEM_NUM_PORTS]
   , output logic [`MEM_NUM_PORTS-1:0] cmd_yumi_o
   , output logic [`MEM_NUM_PORTS-1:0] resp_v_o
   , output mem_resp_s                 resp_o [`MEM_NUM_PORTS]
   , input  logic [`MEM_NUM_PORTS-1:0] resp_ready_i
   );

  port_tag_t grant_tag;

  mem_channel_if mem_if ();

  mem_cmd_arbiter mem_cmd_arbiter_inst
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .cmd_v_i(cmd_v_i)
     , .cmd_i(cmd_i)
     , .cmd_yumi_o(cmd_yumi_o)
     , .grant_tag_o(grant_tag)
     , .mem_if(mem_if.arb)
     );

  mem_model mem_model_inst
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .mem_if(mem_if.mem)
     );

  // Tag from the arbiter is pushed on each command transfer
  mem_resp_router mem_resp_router_inst
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .grant_tag_i(grant_tag)
     , .mem_if(mem_if.route)
     , .resp_v_o(resp_v_o)
     , .resp_o(resp_o)
     , .resp_ready_i(resp_ready_i)
     );

endmodule

// ==== logic/mem_resp_router.sv ====
//********************
// Memory response router
// Tag queue in acceptance order steers each response
// back to the port that issued the command
//********************

`timescale 1ns/100ps

`include "mem_link_consts.svh"

module mem_resp_router
  import mem_link_pkg::*;
  (input  logic                      clk_i
   , input  logic                      rst_i
   , input  port_tag_t                 grant_tag_i
   , mem_channel_if.route              mem_if
   , output logic [`MEM_NUM_PORTS-1:0] resp_v_o
   , output mem_resp_s                 resp_o [`MEM_NUM_PORTS]
   , input  logic [`MEM_NUM_PORTS-1:0] resp_ready_i
   );

  localparam int DEPTH = `MEM_TAG_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  port_tag_t        tag_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  port_tag_t        head;
  logic             push;
  logic             pop;

  assign push = mem_if.cmd_v & mem_if.cmd_yumi;
  assign pop  = mem_if.resp_v & mem_if.resp_ready;
  assign head = tag_q[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      tag_q[wr_ptr_r] <= grant_tag_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_r <= (int'(wr_ptr_r) == DEPTH - 1) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_r <= (int'(rd_ptr_r) == DEPTH - 1) ? '0 : rd_ptr_r + 1'b1;
      end
    end
  end

  // Demux to the head port, others see nothing
  always_comb
  begin
    for (int i = 0; i < `MEM_NUM_PORTS; i++)
    begin
      resp_v_o[i] = 1'b0;
      resp_o[i]   = '0;
    end
    resp_v_o[head] = mem_if.resp_v;
    resp_o[head]   = mem_if.resp;
  end

  assign mem_if.resp_ready = resp_ready_i[head];

endmodule

// ==== logic/mem_model.sv ====
//********************
// Fixed-latency memory model
// Word RAM behind a stallable response pipeline
//********************

`timescale 1ns/100ps

`include "mem_link_consts.svh"

module mem_model
  import mem_link_pkg::*;
  (input  logic           clk_i
   , input  logic           rst_i
   , mem_channel_if.mem     mem_if
   );

  localparam int LAT   = `MEM_LATENCY;
  localparam int WORDS = 2 ** `MEM_ADDR_W;

  logic [`MEM_DATA_W-1:0] ram [WORDS];

  logic [LAT-1:0] pipe_v_r;
  mem_resp_s      pipe_r [LAT];

  logic stall;
  logic accept;

  // Hold everything while the head response waits on its port
  assign stall  = pipe_v_r[LAT-1] & ~mem_if.resp_ready;
  assign accept = mem_if.cmd_v & ~stall;

  assign mem_if.cmd_yumi = accept;

  always_ff @(posedge clk_i)
  begin
    if (accept && (mem_if.cmd.op == MEM_WR))
    begin
      ram[mem_if.cmd.addr] <= mem_if.cmd.data;
    end
  end

  // Payload stages
  always_ff @(posedge clk_i)
  begin
    if (!stall)
    begin
      pipe_r[0].op   <= mem_if.cmd.op;
      pipe_r[0].addr <= mem_if.cmd.addr;
      // Reads sample the RAM before this cycle's write lands
      if (mem_if.cmd.op == MEM_WR)
      begin
        pipe_r[0].data <= mem_if.cmd.data;
      end
      else
      begin
        pipe_r[0].data <= ram[mem_if.cmd.addr];
      end
      for (int k = 1; k < LAT; k++)
      begin
        pipe_r[k] <= pipe_r[k-1];
      end
    end
  end

  // Valid stages
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      pipe_v_r <= '0;
    end
    else if (!stall)
    begin
      pipe_v_r[0] <= accept;
      for (int k = 1; k < LAT; k++)
      begin
        pipe_v_r[k] <= pipe_v_r[k-1];
      end
    end
  end

  assign mem_if.resp_v = pipe_v_r[LAT-1];
  assign mem_if.resp   = pipe_r[LAT-1];

endmodule

// ==== logic/mem_cmd_arbiter.sv ====
//********************
// Memory command arbiter
// Round-robin merge of the port command channels onto one
// memory command channel, with the granted port as tag
//********************

`timescale 1ns/100ps

`include "mem_link_consts.svh"

module mem_cmd_arbiter
  import mem_link_pkg::*;
  (input  logic                      clk_i
   , input  logic                      rst_i
   , input  logic [`MEM_NUM_PORTS-1:0] cmd_v_i
   , input  mem_cmd_s                  cmd_i [`MEM_NUM_PORTS]
   , output logic [`MEM_NUM_PORTS-1:0] cmd_yumi_o
   , output port_tag_t                 grant_tag_o
   , mem_channel_if.arb                mem_if
   );

  localparam int N = `MEM_NUM_PORTS;

  port_tag_t ptr_r;
  logic      found;

  // First valid port at or after the pointer
  always_comb
  begin
    int cand;
    found       = 1'b0;
    grant_tag_o = '0;
    for (int i = 0; i < N; i++)
    begin
      cand = (int'(ptr_r) + i) % N;
      if (!found && cmd_v_i[cand])
      begin
        found       = 1'b1;
        grant_tag_o = port_tag_t'(cand);
      end
    end
  end

  assign mem_if.cmd_v = found;
  assign mem_if.cmd   = cmd_i[grant_tag_o];

  // Yumi goes back to the granted port only
  always_comb
  begin
    cmd_yumi_o              = '0;
    cmd_yumi_o[grant_tag_o] = mem_if.cmd_yumi;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ptr_r <= '0;
    end
    else if (mem_if.cmd_v && mem_if.cmd_yumi)
    begin
      ptr_r <= port_tag_t'((int'(grant_tag_o) + 1) % N);
    end
  end

endmodule

// ==== logic/mem_channel_if.sv ====
//********************
// Merged memory channel
// Command and response channels between arbiter, model and router
//********************

`timescale 1ns/100ps

interface mem_channel_if ();

  // Command channel, valid/yumi
  logic                  cmd_v;
  mem_link_pkg::mem_cmd_s cmd;
  logic                  cmd_yumi;

  // Response channel, valid/ready
  logic                   resp_v;
  mem_link_pkg::mem_resp_s resp;
  logic                   resp_ready;

  modport arb
  (
    output cmd_v,
    output cmd,
    input  cmd_yumi
  );

  modport mem
  (
    input  cmd_v,
    input  cmd,
    output cmd_yumi,
    output resp_v,
    output resp,
    input  resp_ready
  );

  // Router watches command transfers to push tags
  modport route
  (
    input  cmd_v,
    input  cmd_yumi,
    input  resp_v,
    input  resp,
    output resp_ready
  );

endinterface

// ==== logic/mem_link_pkg.sv ====
//********************
// Memory channel types
// Opcode, command and response formats, port tag
//********************

`include "mem_link_consts.svh"

package mem_link_pkg;

  typedef enum logic
  {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_opcode_e;

  typedef struct packed
  {
    mem_opcode_e             op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
  } mem_cmd_s;

  // Data is read data, or the write data echoed back
  typedef struct packed
  {
    mem_opcode_e             op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
  } mem_resp_s;

  // Index of the port that issued a command
  typedef logic [$clog2(`MEM_NUM_PORTS)-1:0] port_tag_t;

endpackage

// ==== include/mem_link_consts.svh ====
//********************
// Memory channel constants
// Port count, widths, model latency and tag queue depth
//********************

`ifndef MEM_LINK_CONSTS_SVH
`define MEM_LINK_CONSTS_SVH

// Requester ports on the shared channel
`define MEM_NUM_PORTS 4

// Word address and data widths
`define MEM_ADDR_W 10
`define MEM_DATA_W 32

// Cycles from command acceptance to response valid
`define MEM_LATENCY 3

// Must cover every command the model can hold in flight
`define MEM_TAG_DEPTH 4

`endif
